// File: Makefile
TOP := ooo_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir

// File: build.f
+incdir+hw
hw/ooo_pkg.sv
hw/dispatch_rename.sv
hw/reservation_station.sv
hw/phys_regfile.sv
hw/alu_unit.sv
hw/reorder_buffer.sv
hw/ooo_core.sv
tests/ooo_core_assertions.sv
tests/ooo_core_tb.sv

// File: hw/alu_unit.sv
`timescale 1ns/10ps

module alu_unit (
    input  logic               clock,
    input  logic               rst,
    input  ooo_pkg::issue_t    issue,
    input  ooo_pkg::data_t     read_data1,
    input  ooo_pkg::data_t     read_data2,
    output ooo_pkg::phys_tag_t read_tag1,
    output ooo_pkg::phys_tag_t read_tag2,
    output ooo_pkg::cdb_t      cdb
);

    ooo_pkg::data_t op_a;
    ooo_pkg::data_t op_b;
    ooo_pkg::data_t result;

    // Operand fetch from the register file
    assign read_tag1 = issue.src1;
    assign read_tag2 = issue.src2;

    assign op_a = read_data1;
    assign op_b = issue.use_imm ? issue.imm : read_data2;

    always_comb begin
        case (issue.op)
            ooo_pkg::ALU_ADD: result = op_a + op_b;
            ooo_pkg::ALU_SUB: result = op_a - op_b;
            ooo_pkg::ALU_AND: result = op_a & op_b;
            ooo_pkg::ALU_OR:  result = op_a | op_b;
            ooo_pkg::ALU_XOR: result = op_a ^ op_b;
            default:          result = op_a;
        endcase
    end

    ////////////////////
    // CDB register
    ////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue.valid;
        end
        // Payload qualified by valid
        cdb.has_dest <= issue.has_dest;
        cdb.tag      <= issue.dest;
        cdb.value    <= result;
        cdb.rob_slot <= issue.rob_slot;
    end

endmodule

// File: hw/dispatch_rename.sv
`timescale 1ns/10ps
`include "ooo_defs.svh"

module dispatch_rename (
    input  logic               clock,
    input  logic               rst,
    input  ooo_pkg::data_t     inst,
    input  logic               inst_valid,
    output logic               inst_accept,
    input  logic               rob_space,
    input  logic               rs_space,
    input  ooo_pkg::rob_idx_t  disp_slot,
    input  ooo_pkg::phys_tag_t free_tag,
    input  logic               free_valid,
    output ooo_pkg::dispatch_t disp
);

    ////////////////////
    // Decode
    ////////////////////

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    ooo_pkg::arch_idx_t  rs1;
    ooo_pkg::arch_idx_t  rs2;
    ooo_pkg::arch_idx_t  rd;
    logic                is_op;
    logic                is_opimm;
    logic                known;
    logic                has_dest;
    ooo_pkg::alu_op_t    alu_op;

    // Speculative rename state
    ooo_pkg::phys_tag_t          map_table [`OOO_ARCH_REGS];
    logic [`OOO_PHYS_REGS-1:0]   free_mask;
    ooo_pkg::phys_tag_t          alloc_tag;
    logic                        free_any;
    logic                        dispatch;

    // Standard RV32 field positions
    assign opcode   = inst[6:0];
    assign rd       = inst[11:7];
    assign funct3   = inst[14:12];
    assign rs1      = inst[19:15];
    assign rs2      = inst[24:20];
    assign is_op    = (opcode == `OOO_OPC_OP);
    assign is_opimm = (opcode == `OOO_OPC_OPIMM);

    always_comb begin
        alu_op = ooo_pkg::ALU_PASS;
        known  = 1'b0;
        if (is_op) begin
            known = 1'b1;
            case (funct3)
                // inst[30] splits ADD from SUB
                3'b000:  alu_op = inst[30] ? ooo_pkg::ALU_SUB : ooo_pkg::ALU_ADD;
                3'b100:  alu_op = ooo_pkg::ALU_XOR;
                3'b110:  alu_op = ooo_pkg::ALU_OR;
                3'b111:  alu_op = ooo_pkg::ALU_AND;
                default: known = 1'b0;
            endcase
        end else if (is_opimm && funct3 == 3'b000) begin
            // ADDI only
            known  = 1'b1;
            alu_op = ooo_pkg::ALU_ADD;
        end
    end

    // Writes to x0 are dropped
    assign has_dest = known && (rd != '0);

    ////////////////////
    // Free list pick
    ////////////////////

    // Downward scan leaves the lowest free register
    always_comb begin
        alloc_tag = '0;
        free_any  = 1'b0;
        for (int i = `OOO_PHYS_REGS - 1; i >= 0; i--) begin
            if (free_mask[i]) begin
                alloc_tag = ooo_pkg::phys_tag_t'(i);
                free_any  = 1'b1;
            end
        end
    end

    assign inst_accept = rob_space && rs_space && (!has_dest || free_any);
    assign dispatch    = inst_valid && inst_accept;

    // Dispatch packet
    always_comb begin
        disp.valid     = dispatch;
        disp.op        = alu_op;
        // Unknown ops read p0, always ready
        disp.src1      = known ? map_table[rs1] : '0;
        disp.src2      = (known && is_op) ? map_table[rs2] : '0;
        disp.use_imm   = known && is_opimm;
        disp.imm       = ooo_pkg::data_t'($signed(inst[31:20]));
        disp.has_dest  = has_dest;
        disp.arch_dest = rd;
        disp.dest      = has_dest ? alloc_tag : '0;
        disp.old_dest  = map_table[rd];
        disp.rob_slot  = disp_slot;
    end

    ////////////////////
    // Rename state
    ////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            // Identity map, upper half free
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                map_table[i] <= ooo_pkg::phys_tag_t'(i);
            end
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                free_mask[i] <= (i >= `OOO_ARCH_REGS);
            end
        end else begin
            // Retired old mapping comes back
            if (free_valid) begin
                free_mask[free_tag] <= 1'b1;
            end
            if (dispatch && has_dest) begin
                free_mask[alloc_tag] <= 1'b0;
                map_table[rd]        <= alloc_tag;
            end
        end
    end

endmodule

// File: hw/ooo_core.sv
`timescale 1ns/10ps

module ooo_core (
    input  logic             clock,
    input  logic             rst,
    input  ooo_pkg::data_t   inst,
    input  logic             inst_valid,
    output logic             inst_accept,
    output ooo_pkg::commit_t commit
);

    ////////////////////
    // Core wires
    ////////////////////

    ooo_pkg::dispatch_t disp;
    ooo_pkg::rob_idx_t  disp_slot;
    logic               rob_space;
    logic               rs_space;
    logic               src1_ready;
    logic               src2_ready;
    ooo_pkg::issue_t    issue;
    ooo_pkg::phys_tag_t read_tag1;
    ooo_pkg::phys_tag_t read_tag2;
    ooo_pkg::data_t     read_data1;
    ooo_pkg::data_t     read_data2;
    ooo_pkg::cdb_t      cdb;
    ooo_pkg::phys_tag_t free_tag;
    logic               free_valid;

    // Decode and rename
    dispatch_rename dispatch_rename_0 (
        .clock      (clock),
        .rst        (rst),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_accept(inst_accept),
        .rob_space  (rob_space),
        .rs_space   (rs_space),
        .disp_slot  (disp_slot),
        .free_tag   (free_tag),
        .free_valid (free_valid),
        .disp       (disp)
    );

    // Wakeup and select
    reservation_station reservation_station_0 (
        .clock     (clock),
        .rst       (rst),
        .disp      (disp),
        .src1_ready(src1_ready),
        .src2_ready(src2_ready),
        .cdb       (cdb),
        .rs_space  (rs_space),
        .issue     (issue)
    );

    phys_regfile phys_regfile_0 (
        .clock     (clock),
        .rst       (rst),
        .disp      (disp),
        .cdb       (cdb),
        .read_tag1 (read_tag1),
        .read_tag2 (read_tag2),
        .read_data1(read_data1),
        .read_data2(read_data2),
        .src1_ready(src1_ready),
        .src2_ready(src2_ready)
    );

    // Sole CDB driver
    alu_unit alu_unit_0 (
        .clock     (clock),
        .rst       (rst),
        .issue     (issue),
        .read_data1(read_data1),
        .read_data2(read_data2),
        .read_tag1 (read_tag1),
        .read_tag2 (read_tag2),
        .cdb       (cdb)
    );

    // In-order retire
    reorder_buffer reorder_buffer_0 (
        .clock     (clock),
        .rst       (rst),
        .disp      (disp),
        .cdb       (cdb),
        .rob_space (rob_space),
        .disp_slot (disp_slot),
        .free_tag  (free_tag),
        .free_valid(free_valid),
        .commit    (commit)
    );

endmodule

// File: hw/ooo_defs.svh
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

////////////////////
// Datapath sizes
////////////////////

// Integer register width
`define OOO_XLEN 32

// RV32 architectural register count
`define OOO_ARCH_REGS 32

// Physical registers, twice the architectural set
`define OOO_PHYS_REGS 64

// In-flight window
`define OOO_ROB_DEPTH 8
`define OOO_RS_DEPTH 4

////////////////////
// Opcodes
////////////////////

// R-type ALU ops
`define OOO_OPC_OP 7'b0110011
// I-type ALU ops
`define OOO_OPC_OPIMM 7'b0010011

`endif

// File: hw/ooo_pkg.sv
`include "ooo_defs.svh"

package ooo_pkg;

    ////////////////////
    // Scalar types
    ////////////////////

    typedef logic [`OOO_XLEN-1:0] data_t;
    typedef logic [$clog2(`OOO_ARCH_REGS)-1:0] arch_idx_t;
    typedef logic [$clog2(`OOO_PHYS_REGS)-1:0] phys_tag_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_idx_t;

    // Pass forwards operand A, used for no-ops
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS
    } alu_op_t;

    ////////////////////
    // Bundles
    ////////////////////

    // Renamed instruction leaving dispatch
    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        phys_tag_t src1;
        phys_tag_t src2;
        logic      use_imm;
        data_t     imm;
        logic      has_dest;
        arch_idx_t arch_dest;
        phys_tag_t dest;
        phys_tag_t old_dest;  // mapping replaced by dest, freed at commit
        rob_idx_t  rob_slot;
    } dispatch_t;

    // Operation selected by the station
    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        phys_tag_t src1;
        phys_tag_t src2;
        logic      use_imm;
        data_t     imm;
        logic      has_dest;
        phys_tag_t dest;
        rob_idx_t  rob_slot;
    } issue_t;

    // Result broadcast
    typedef struct packed {
        logic      valid;
        logic      has_dest;
        phys_tag_t tag;
        data_t     value;
        rob_idx_t  rob_slot;
    } cdb_t;

    // In-order retirement
    typedef struct packed {
        logic      valid;
        logic      has_dest;
        arch_idx_t arch_dest;
        data_t     value;
    } commit_t;

endpackage

// File: hw/phys_regfile.sv
`timescale 1ns/10ps
`include "ooo_defs.svh"

module phys_regfile (
    input  logic               clock,
    input  logic               rst,
    input  ooo_pkg::dispatch_t disp,
    input  ooo_pkg::cdb_t      cdb,
    input  ooo_pkg::phys_tag_t read_tag1,
    input  ooo_pkg::phys_tag_t read_tag2,
    output ooo_pkg::data_t     read_data1,
    output ooo_pkg::data_t     read_data2,
    output logic               src1_ready,
    output logic               src2_ready
);

    ooo_pkg::data_t            regs [`OOO_PHYS_REGS];
    logic [`OOO_PHYS_REGS-1:0] ready;

    // p0 is hard zero
    assign read_data1 = (read_tag1 == '0) ? '0 : regs[read_tag1];
    assign read_data2 = (read_tag2 == '0) ? '0 : regs[read_tag2];

    // Ready lookup for the dispatching sources
    assign src1_ready = (disp.src1 == '0) || ready[disp.src1];
    assign src2_ready = (disp.src2 == '0) || ready[disp.src2];

    always_ff @(posedge clock) begin
        if (rst) begin
            // Architectural state starts as zeros in p0..p31
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                regs[i]  <= '0;
                ready[i] <= (i < `OOO_ARCH_REGS);
            end
        end else begin
            // New destination waits for its producer
            if (disp.valid && disp.has_dest) begin
                ready[disp.dest] <= 1'b0;
            end
            if (cdb.valid && cdb.has_dest) begin
                regs[cdb.tag]  <= cdb.value;
                ready[cdb.tag] <= 1'b1;
            end
        end
    end

endmodule

// File: hw/reorder_buffer.sv
`timescale 1ns/10ps
`include "ooo_defs.svh"

module reorder_buffer (
    input  logic               clock,
    input  logic               rst,
    input  ooo_pkg::dispatch_t disp,
    input  ooo_pkg::cdb_t      cdb,
    output logic               rob_space,
    output ooo_pkg::rob_idx_t  disp_slot,
    output ooo_pkg::phys_tag_t free_tag,
    output logic               free_valid,
    output ooo_pkg::commit_t   commit
);

    typedef struct packed {
        logic               has_dest;
        ooo_pkg::arch_idx_t arch_dest;
        ooo_pkg::phys_tag_t old_tag;
        logic               done;
        ooo_pkg::data_t     value;
    } rob_entry_t;

    rob_entry_t                           entries [`OOO_ROB_DEPTH];
    ooo_pkg::rob_idx_t                    head;
    ooo_pkg::rob_idx_t                    tail;
    logic [$clog2(`OOO_ROB_DEPTH+1)-1:0]  count;
    logic                                 cdb_at_head;
    logic                                 head_ready;
    ooo_pkg::data_t                       head_value;

    assign rob_space = (count != `OOO_ROB_DEPTH);
    assign disp_slot = tail;

    // Head may finish on this cycle's broadcast
    assign cdb_at_head = cdb.valid && (cdb.rob_slot == head);
    assign head_ready  = (count != '0) && (entries[head].done || cdb_at_head);
    assign head_value  = entries[head].done ? entries[head].value : cdb.value;

    always_ff @(posedge clock) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            commit.valid <= 1'b0;
            free_valid <= 1'b0;
        end else begin
            commit.valid <= head_ready;
            free_valid   <= head_ready && entries[head].has_dest;
            if (head_ready) head <= head + 1'b1;
            if (disp.valid) tail <= tail + 1'b1;
            // Occupancy
            if (disp.valid && !head_ready) begin
                count <= count + 1'b1;
            end else if (!disp.valid && head_ready) begin
                count <= count - 1'b1;
            end
        end
        // Completion from CDB
        if (cdb.valid) begin
            entries[cdb.rob_slot].done  <= 1'b1;
            entries[cdb.rob_slot].value <= cdb.value;
        end
        // Allocation at tail
        if (disp.valid) begin
            entries[tail].has_dest  <= disp.has_dest;
            entries[tail].arch_dest <= disp.arch_dest;
            entries[tail].old_tag   <= disp.old_dest;
            entries[tail].done      <= 1'b0;
        end
        commit.has_dest  <= entries[head].has_dest;
        commit.arch_dest <= entries[head].arch_dest;
        commit.value     <= head_value;
        free_tag         <= entries[head].old_tag;
    end

endmodule

// File: hw/reservation_station.sv
`timescale 1ns/10ps
`include "ooo_defs.svh"

module reservation_station (
    input  logic               clock,
    input  logic               rst,
    input  ooo_pkg::dispatch_t disp,
    input  logic               src1_ready,
    input  logic               src2_ready,
    input  ooo_pkg::cdb_t      cdb,
    output logic               rs_space,
    output ooo_pkg::issue_t    issue
);

    localparam int IDX_W = $clog2(`OOO_RS_DEPTH);

    // Entry payload, valid field marks occupancy
    ooo_pkg::issue_t            slots [`OOO_RS_DEPTH];
    logic [`OOO_RS_DEPTH-1:0]   rdy1;
    logic [`OOO_RS_DEPTH-1:0]   rdy2;
    logic [IDX_W-1:0]           alloc_idx;
    logic [IDX_W-1:0]           issue_idx;
    ooo_pkg::issue_t            alloc_entry;
    logic                       cdb_hit1;
    logic                       cdb_hit2;

    ////////////////////
    // Select logic
    ////////////////////

    // Lowest empty entry
    always_comb begin
        alloc_idx = '0;
        rs_space  = 1'b0;
        for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
            if (!slots[i].valid) begin
                alloc_idx = IDX_W'(i);
                rs_space  = 1'b1;
            end
        end
    end

    // Lowest ready entry wins
    always_comb begin
        issue     = '0;
        issue_idx = '0;
        for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
            if (slots[i].valid && rdy1[i] && rdy2[i]) begin
                issue     = slots[i];
                issue_idx = IDX_W'(i);
            end
        end
    end

    // Same-cycle broadcast for a dispatching source
    assign cdb_hit1 = cdb.valid && cdb.has_dest && (cdb.tag == disp.src1);
    assign cdb_hit2 = cdb.valid && cdb.has_dest && (cdb.tag == disp.src2);

    always_comb begin
        alloc_entry.valid    = 1'b1;
        alloc_entry.op       = disp.op;
        alloc_entry.src1     = disp.src1;
        alloc_entry.src2     = disp.src2;
        alloc_entry.use_imm  = disp.use_imm;
        alloc_entry.imm      = disp.imm;
        alloc_entry.has_dest = disp.has_dest;
        alloc_entry.dest     = disp.dest;
        alloc_entry.rob_slot = disp.rob_slot;
    end

    ////////////////////
    // Entry update
    ////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
                slots[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
                // Tag wakeup
                if (cdb.valid && cdb.has_dest) begin
                    if (slots[i].src1 == cdb.tag) rdy1[i] <= 1'b1;
                    if (slots[i].src2 == cdb.tag) rdy2[i] <= 1'b1;
                end
                if (issue.valid && issue_idx == IDX_W'(i)) begin
                    slots[i].valid <= 1'b0;
                end
            end
            // Allocation never targets the issuing entry
            if (disp.valid) begin
                slots[alloc_idx] <= alloc_entry;
                rdy1[alloc_idx]  <= src1_ready || cdb_hit1;
                rdy2[alloc_idx]  <= disp.use_imm || src2_ready || cdb_hit2;
            end
        end
    end

endmodule

// File: tests/ooo_core_assertions.sv
`timescale 1ns/10ps
`include "ooo_defs.svh"

module ooo_core_assertions (
    input logic             clock,
    input logic             rst,
    input ooo_pkg::data_t   inst,
    input logic             inst_valid,
    input logic             inst_accept,
    input ooo_pkg::commit_t commit
);

    // Expectation ring, deeper than the ROB
    localparam int EXP_DEPTH = 16;

    ooo_pkg::data_t   golden [`OOO_ARCH_REGS];
    ooo_pkg::commit_t expect_mem [EXP_DEPTH];
    ooo_pkg::commit_t predicted;
    ooo_pkg::commit_t exp_head;
    ooo_pkg::data_t   op_a;
    ooo_pkg::data_t   op_b;
    ooo_pkg::data_t   imm;
    logic             dispatch_now;
    logic             exp_avail;
    int               dispatched;
    int               committed;
    int               stall_cycles;
    int               errors = 0;

    ////////////////////
    // Golden model
    ////////////////////

    assign dispatch_now = inst_valid && inst_accept;
    assign op_a         = golden[inst[19:15]];
    assign op_b         = golden[inst[24:20]];
    // I-type immediate, sign-extended
    assign imm          = {{20{inst[31]}}, inst[31:20]};
    assign exp_avail    = (dispatched != committed);
    assign exp_head     = expect_mem[committed % EXP_DEPTH];

    // RV32 semantics of the supported subset
    always_comb begin
        predicted           = '0;
        predicted.valid     = 1'b1;
        predicted.arch_dest = inst[11:7];
        if (inst[6:0] == `OOO_OPC_OP) begin
            predicted.has_dest = 1'b1;
            case (inst[14:12])
                3'b000:  predicted.value = inst[30] ? op_a - op_b : op_a + op_b;
                3'b100:  predicted.value = op_a ^ op_b;
                3'b110:  predicted.value = op_a | op_b;
                3'b111:  predicted.value = op_a & op_b;
                default: predicted.has_dest = 1'b0;
            endcase
        end else if (inst[6:0] == `OOO_OPC_OPIMM && inst[14:12] == 3'b000) begin
            predicted.has_dest = 1'b1;
            predicted.value    = op_a + imm;
        end
        // x0 never written
        if (inst[11:7] == 5'd0) begin
            predicted.has_dest = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                golden[i] <= '0;
            end
            dispatched   <= 0;
            committed    <= 0;
            stall_cycles <= 0;
        end else begin
            // Dispatch order is program order
            if (dispatch_now) begin
                expect_mem[dispatched % EXP_DEPTH] <= predicted;
                dispatched <= dispatched + 1;
                if (predicted.has_dest) begin
                    golden[predicted.arch_dest] <= predicted.value;
                end
            end
            if (commit.valid) begin
                committed <= committed + 1;
            end
            // Cycles without retirement while work is pending
            if (commit.valid || !exp_avail) begin
                stall_cycles <= 0;
            end else begin
                stall_cycles <= stall_cycles + 1;
            end
        end
    end

    ////////////////////
    // Properties
    ////////////////////

    a_reset_quiet: assert property (@(posedge clock)
        $past(rst) |-> !commit.valid && inst_accept)
    else begin
        errors++;
        $error("Commit seen or dispatch refused during or right after reset");
    end

    a_commit_expected: assert property (@(posedge clock) disable iff (rst)
        commit.valid |-> exp_avail)
    else begin
        errors++;
        $error("Commit arrived with no dispatched instruction outstanding");
    end

    a_commit_has_dest: assert property (@(posedge clock) disable iff (rst)
        commit.valid && exp_avail |-> commit.has_dest == exp_head.has_dest)
    else begin
        errors++;
        $error("[ERROR] %0t commit.has_dest got %0b expected %0b", $time,
            $sampled(commit.has_dest), $sampled(exp_head.has_dest));
    end

    a_commit_dest: assert property (@(posedge clock) disable iff (rst)
        commit.valid && exp_avail && exp_head.has_dest |->
        commit.arch_dest == exp_head.arch_dest)
    else begin
        errors++;
        $error("[ERROR] %0t commit.arch_dest got %0d expected %0d", $time,
            $sampled(commit.arch_dest), $sampled(exp_head.arch_dest));
    end

    a_commit_value: assert property (@(posedge clock) disable iff (rst)
        commit.valid && exp_avail && exp_head.has_dest |-> commit.value == exp_head.value)
    else begin
        errors++;
        $error("[ERROR] %0t commit.value got %h expected %h", $time,
            $sampled(commit.value), $sampled(exp_head.value));
    end

    // In-flight window bounded by the ROB
    a_window: assert property (@(posedge clock) disable iff (rst)
        dispatched - committed <= `OOO_ROB_DEPTH)
    else begin
        errors++;
        $error("More instructions in flight than the ROB can hold");
    end

    a_progress: assert property (@(posedge clock) disable iff (rst)
        stall_cycles <= 20)
    else begin
        errors++;
        $error("No commit for 20 cycles with instructions in flight");
    end

endmodule

// File: tests/ooo_core_tb.sv
`timescale 1ns/10ps
`include "ooo_defs.svh"

module ooo_core_tb;

    localparam int NUM_TESTS       = 6;
    localparam int TEST_INSTS      = 200;
    localparam int CYCLES_PER_INST = 20;
    localparam int CLOCK_NS        = 8;
    localparam int SEED            = 281;

    logic             clock;
    logic             rst;
    ooo_pkg::data_t   inst;
    logic             inst_valid;
    logic             inst_accept;
    ooo_pkg::commit_t commit;
    ooo_pkg::data_t   raw_word;
    int               err_mark;
    int               total;
    int               prev_rd;
    int               next_rd;

    ooo_core dut_i (
        .clock      (clock),
        .rst        (rst),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_accept(inst_accept),
        .commit     (commit)
    );

    // Golden model and properties ride inside the core
    bind ooo_core ooo_core_assertions checks_i (
        .clock      (clock),
        .rst        (rst),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_accept(inst_accept),
        .commit     (commit)
    );

    initial clock = 1'b0;
    always #(CLOCK_NS / 2) clock = ~clock;

    ////////////////////
    // Encoders
    ////////////////////

    // sel 0..4 is ADD, SUB, AND, OR, XOR
    function automatic ooo_pkg::data_t rtype_word(input int sel, input int rd,
                                                  input int rs1, input int rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = 7'h00;
        case (sel)
            0: f3 = 3'b000;
            1: begin
                f3 = 3'b000;
                f7 = 7'h20;
            end
            2: f3 = 3'b111;
            3: f3 = 3'b110;
            default: f3 = 3'b100;
        endcase
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `OOO_OPC_OP};
    endfunction

    function automatic ooo_pkg::data_t addi_word(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), `OOO_OPC_OPIMM};
    endfunction

    // Any of the six supported ops
    function automatic ooo_pkg::data_t random_op_word(input int rd, input int rs1,
                                                      input int rs2);
        int sel;
        sel = $urandom % 6;
        if (sel == 5) begin
            return addi_word(rd, rs1, $urandom % 4096);
        end
        return rtype_word(sel, rd, rs1, rs2);
    endfunction

    ////////////////////
    // Driver tasks
    ////////////////////

    // Holds the word until the core takes it
    task automatic send_inst(input ooo_pkg::data_t word);
        logic taken;
        inst       = word;
        inst_valid = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clock);
            taken = inst_accept;
            @(posedge clock);
            #1;
        end
        inst_valid = 1'b0;
    endtask

    task automatic drain_core();
        while (dut_i.checks_i.dispatched != dut_i.checks_i.committed) begin
            @(negedge clock);
        end
        repeat (2) @(posedge clock);
        #1;
    endtask

    task automatic report_test(input string name);
        int delta;
        delta    = dut_i.checks_i.errors - err_mark;
        err_mark = dut_i.checks_i.errors;
        $display("Test %-12s errors %0d", name, delta);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        void'($urandom(SEED));
        rst        = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        err_mark   = 0;
        repeat (5) @(posedge clock);
        #1;
        rst = 1'b0;
        repeat (3) @(posedge clock);
        #1;
        report_test("reset");

        // Seed x16..x30 before ops that read only those
        for (int i = 16; i < 31; i++) begin
            send_inst(addi_word(i, 0, $urandom % 4096));
        end
        for (int i = 0; i < 40; i++) begin
            send_inst(random_op_word(1 + i % 15, 16 + $urandom % 15, 16 + $urandom % 15));
        end
        drain_core();
        report_test("independent");

        // Each op reads the previous destination
        prev_rd = 1;
        for (int i = 0; i < 60; i++) begin
            next_rd = 1 + $urandom % 7;
            send_inst(random_op_word(next_rd, prev_rd, 16 + $urandom % 15));
            prev_rd = next_rd;
        end
        drain_core();
        report_test("chains");

        // Few destinations and many renames
        for (int i = 0; i < TEST_INSTS; i++) begin
            send_inst(random_op_word(1 + $urandom % 3, 1 + $urandom % 5, 1 + $urandom % 5));
        end
        drain_core();
        report_test("recycling");

        // Back-to-back serial chain fills the station and ROB
        for (int i = 0; i < 48; i++) begin
            send_inst(random_op_word(9, 9, 9 + $urandom % 2));
        end
        drain_core();
        report_test("backpressure");

        // rd = 0, SLL and branch opcodes retire without a destination
        send_inst(random_op_word(0, 3, 4));
        send_inst(addi_word(0, 5, 77));
        send_inst({7'h00, 5'd2, 5'd3, 3'b001, 5'd4, `OOO_OPC_OP});
        raw_word      = $urandom;
        raw_word[6:0] = 7'b1100011;
        send_inst(raw_word);
        send_inst(rtype_word(0, 11, 0, 5));
        send_inst(addi_word(12, 0, 123));
        send_inst(rtype_word(4, 13, 0, 0));
        send_inst(rtype_word(0, 14, 11, 12));
        drain_core();
        report_test("x0_unknown");

        total = dut_i.checks_i.errors;
        $display("Tests %0d, dispatched %0d, committed %0d, errors %0d", NUM_TESTS,
                 dut_i.checks_i.dispatched, dut_i.checks_i.committed, total);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the test lengths
    initial begin
        #(NUM_TESTS * TEST_INSTS * CYCLES_PER_INST * CLOCK_NS);
        $display("Timeout: the core stopped accepting or committing instructions");
        $display("Regression failed");
        $finish;
    end

endmodule
